// ==== hw/gpu_ctrl_defs.svh ====
`ifndef GPU_CTRL_DEFS_SVH
`define GPU_CTRL_DEFS_SVH

// host and memory data word width
`define GPU_DATA_W 32

// byte address width, memory and core side
`define GPU_ADDR_W 32

// address step from one word to the next
`define GPU_WORD_BYTES 4

`endif

// ==== hw/gpu_ctrl_pkg.sv ====
package gpu_ctrl_pkg;

    `include "gpu_ctrl_defs.svh"

    typedef logic [`GPU_DATA_W-1:0] data_t;
    typedef logic [`GPU_ADDR_W-1:0] addr_t;
    // transfer length in bytes, word multiple
    typedef logic [31:0] byte_count_t;

    // host opcodes, one full word each
    typedef enum logic [31:0] {
        INSTR_NOP           = 32'd0,
        INSTR_COPY_TO_GPU   = 32'd1,
        INSTR_COPY_FROM_GPU = 32'd2,
        INSTR_KERNEL_LAUNCH = 32'd3
    } instr_e;

    typedef enum logic [1:0] {DEC_IDLE, DEC_PARAMS, DEC_BUSY} dec_state_e;

    typedef enum logic [1:0] {DMA_IDLE, DMA_WRITE, DMA_READ} dma_state_e;

    typedef enum logic [1:0] {LAUNCH_IDLE, LAUNCH_SET_PC, LAUNCH_RUN} launch_state_e;

endpackage

// ==== hw/cmd_decoder.sv ====
`timescale 1ns/100ps

module cmd_decoder
    import gpu_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  instr_e      cpu_recv_instr,
    input  data_t       cpu_in_data,
    input  logic        dma_done,
    input  logic        launch_done,
    output logic        start_write,
    output logic        start_read,
    output logic        start_launch,
    output addr_t       xfer_base,
    output byte_count_t xfer_bytes
);

    dec_state_e state;
    // opcode held while parameters arrive
    instr_e     opcode;
    // index of the parameter word on cpu_in_data
    logic       param_pos;
    // first parameter word, base address of a copy
    addr_t      base_q;
    logic       last_param;

    // index of the final parameter word
    // copies take base and count, launch only the kernel address
    function automatic logic last_param_pos(instr_e op);
        logic pos;
        pos = 1'b1;
        if (op == INSTR_KERNEL_LAUNCH) begin
            pos = 1'b0;
        end
        return pos;
    endfunction

    assign last_param = (state == DEC_PARAMS) && (param_pos == last_param_pos(opcode));

    // one start pulse, in the cycle of the last parameter
    assign start_write  = last_param && (opcode == INSTR_COPY_TO_GPU);
    assign start_read   = last_param && (opcode == INSTR_COPY_FROM_GPU);
    assign start_launch = last_param && (opcode == INSTR_KERNEL_LAUNCH);

    // count is always the live word
    assign xfer_bytes = byte_count_t'(cpu_in_data);
    // launch has a single parameter, so its address is still on the bus
    assign xfer_base  = (param_pos == 1'b0) ? addr_t'(cpu_in_data) : base_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state     <= DEC_IDLE;
            opcode    <= INSTR_NOP;
            param_pos <= 1'b0;
        end else begin
            case (state)
                DEC_IDLE: begin
                    param_pos <= 1'b0;
                    // nop and unknown opcodes leave us idle
                    if ((cpu_recv_instr == INSTR_COPY_TO_GPU) ||
                        (cpu_recv_instr == INSTR_COPY_FROM_GPU) ||
                        (cpu_recv_instr == INSTR_KERNEL_LAUNCH)) begin
                        opcode <= cpu_recv_instr;
                        state  <= DEC_PARAMS;
                    end
                end
                DEC_PARAMS: begin
                    param_pos <= param_pos + 1'b1;
                    if (last_param) begin
                        state <= DEC_BUSY;
                    end
                end
                DEC_BUSY: begin
                    // instruction bus ignored until the engine finishes
                    if (dma_done || launch_done) begin
                        state <= DEC_IDLE;
                    end
                end
                default: begin
                    state <= DEC_IDLE;
                end
            endcase
        end
    end

    // capture base address from the first parameter word
    always_ff @(posedge clk) begin
        if ((state == DEC_PARAMS) && (param_pos == 1'b0)) begin
            base_q <= addr_t'(cpu_in_data);
        end
    end

endmodule

// ==== hw/dma_engine.sv ====
`timescale 1ns/100ps

`include "gpu_ctrl_defs.svh"

module dma_engine
    import gpu_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        start_write,
    input  logic        start_read,
    input  addr_t       xfer_base,
    input  byte_count_t xfer_bytes,
    input  data_t       cpu_in_data,
    input  data_t       mem_rd_data,
    input  logic        mem_rd_ack,
    input  logic        launch_done,
    output logic        mem_wr_en,
    output addr_t       mem_wr_addr,
    output data_t       mem_wr_data,
    output logic        mem_rd_en,
    output addr_t       mem_rd_addr,
    output data_t       cpu_out_data,
    output logic        cpu_out_ack,
    output logic        dma_done
);

    dma_state_e state;
    // address of the next word to move
    addr_t      next_addr;
    // one past the last byte, fixed at start
    addr_t      end_addr;
    addr_t      step_addr;
    logic       rd_ack_q;
    logic       rd_first;
    logic       rd_return;

    assign step_addr = next_addr + addr_t'(`GPU_WORD_BYTES);

    // first request of a read transfer
    assign rd_first  = (state == DMA_IDLE) && start_read;
    // memory answered the request in flight, only one at a time in READ
    assign rd_return = (state == DMA_READ) && mem_rd_ack;

    // read words and the launch completion share the host return channel
    // cpu_out_data is zero in the launch cycle
    assign cpu_out_ack = rd_ack_q | launch_done;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state        <= DMA_IDLE;
            next_addr    <= '0;
            end_addr     <= '0;
            rd_ack_q     <= 1'b0;
            mem_wr_en    <= 1'b0;
            mem_rd_en    <= 1'b0;
            dma_done     <= 1'b0;
            cpu_out_data <= '0;
        end else begin
            // strobes default low, host data zero unless a word returns
            mem_wr_en    <= 1'b0;
            mem_rd_en    <= 1'b0;
            rd_ack_q     <= 1'b0;
            dma_done     <= 1'b0;
            cpu_out_data <= '0;
            case (state)
                DMA_IDLE: begin
                    if (start_write) begin
                        state     <= DMA_WRITE;
                        next_addr <= xfer_base;
                        end_addr  <= xfer_base + addr_t'(xfer_bytes);
                    end else if (rd_first) begin
                        // first request leaves right away
                        state     <= DMA_READ;
                        mem_rd_en <= 1'b1;
                        next_addr <= xfer_base + addr_t'(`GPU_WORD_BYTES);
                        end_addr  <= xfer_base + addr_t'(xfer_bytes);
                    end
                end
                DMA_WRITE: begin
                    // one host word per cycle, no stalls
                    mem_wr_en <= 1'b1;
                    next_addr <= step_addr;
                    if (step_addr == end_addr) begin
                        dma_done <= 1'b1;
                        state    <= DMA_IDLE;
                    end
                end
                DMA_READ: begin
                    if (rd_return) begin
                        rd_ack_q     <= 1'b1;
                        cpu_out_data <= mem_rd_data;
                        if (next_addr == end_addr) begin
                            // last word delivered
                            dma_done <= 1'b1;
                            state    <= DMA_IDLE;
                        end else begin
                            // next request goes out with this word
                            mem_rd_en <= 1'b1;
                            next_addr <= step_addr;
                        end
                    end
                end
                default: begin
                    state <= DMA_IDLE;
                end
            endcase
        end
    end

    // memory address and data
    always_ff @(posedge clk) begin
        if (state == DMA_WRITE) begin
            mem_wr_addr <= next_addr;
            mem_wr_data <= cpu_in_data;
        end
        if (rd_first) begin
            mem_rd_addr <= xfer_base;
        end else if (rd_return) begin
            mem_rd_addr <= next_addr;
        end
    end

endmodule

// ==== hw/kernel_launcher.sv ====
`timescale 1ns/100ps

module kernel_launcher
    import gpu_ctrl_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  start_launch,
    input  addr_t xfer_base,
    input  logic  core_halt,
    output logic  core_set_pc_req,
    output addr_t core_set_pc_addr,
    output logic  core_ena,
    output logic  core_clr,
    output logic  launch_done
);

    launch_state_e state;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state           <= LAUNCH_IDLE;
            core_set_pc_req <= 1'b0;
            core_ena        <= 1'b0;
            core_clr        <= 1'b0;
            launch_done     <= 1'b0;
        end else begin
            // single cycle pulses
            core_set_pc_req <= 1'b0;
            core_clr        <= 1'b0;
            launch_done     <= 1'b0;
            case (state)
                LAUNCH_IDLE: begin
                    if (start_launch) begin
                        core_set_pc_req <= 1'b1;
                        state           <= LAUNCH_SET_PC;
                    end
                end
                LAUNCH_SET_PC: begin
                    // pc loaded, let the core run
                    core_ena <= 1'b1;
                    state    <= LAUNCH_RUN;
                end
                LAUNCH_RUN: begin
                    // stop, clear the core and tell the host
                    if (core_halt) begin
                        core_ena    <= 1'b0;
                        core_clr    <= 1'b1;
                        launch_done <= 1'b1;
                        state       <= LAUNCH_IDLE;
                    end
                end
                default: begin
                    state <= LAUNCH_IDLE;
                end
            endcase
        end
    end

    // kernel address, valid with core_set_pc_req
    always_ff @(posedge clk) begin
        if ((state == LAUNCH_IDLE) && start_launch) begin
            core_set_pc_addr <= xfer_base;
        end
    end

endmodule

// ==== hw/gpu_ctrl_top.sv ====
`timescale 1ns/100ps

module gpu_ctrl_top
    import gpu_ctrl_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    // host
    input  instr_e cpu_recv_instr,
    input  data_t  cpu_in_data,
    output data_t  cpu_out_data,
    output logic   cpu_out_ack,
    // gpu memory
    output logic   mem_wr_en,
    output addr_t  mem_wr_addr,
    output data_t  mem_wr_data,
    output logic   mem_rd_en,
    output addr_t  mem_rd_addr,
    input  data_t  mem_rd_data,
    input  logic   mem_rd_ack,
    // core
    output logic   core_set_pc_req,
    output addr_t  core_set_pc_addr,
    output logic   core_ena,
    output logic   core_clr,
    input  logic   core_halt
);

    // decoder to engines
    logic        start_write;
    logic        start_read;
    logic        start_launch;
    addr_t       xfer_base;
    byte_count_t xfer_bytes;
    // completion back to decoder
    logic        dma_done;
    logic        launch_done;

    cmd_decoder i_cmd_decoder (
        .clk            (clk),
        .rst            (rst),
        .cpu_recv_instr (cpu_recv_instr),
        .cpu_in_data    (cpu_in_data),
        .dma_done       (dma_done),
        .launch_done    (launch_done),
        .start_write    (start_write),
        .start_read     (start_read),
        .start_launch   (start_launch),
        .xfer_base      (xfer_base),
        .xfer_bytes     (xfer_bytes)
    );

    dma_engine i_dma_engine (
        .clk          (clk),
        .rst          (rst),
        .start_write  (start_write),
        .start_read   (start_read),
        .xfer_base    (xfer_base),
        .xfer_bytes   (xfer_bytes),
        .cpu_in_data  (cpu_in_data),
        .mem_rd_data  (mem_rd_data),
        .mem_rd_ack   (mem_rd_ack),
        .launch_done  (launch_done),
        .mem_wr_en    (mem_wr_en),
        .mem_wr_addr  (mem_wr_addr),
        .mem_wr_data  (mem_wr_data),
        .mem_rd_en    (mem_rd_en),
        .mem_rd_addr  (mem_rd_addr),
        .cpu_out_data (cpu_out_data),
        .cpu_out_ack  (cpu_out_ack),
        .dma_done     (dma_done)
    );

    kernel_launcher i_kernel_launcher (
        .clk              (clk),
        .rst              (rst),
        .start_launch     (start_launch),
        .xfer_base        (xfer_base),
        .core_halt        (core_halt),
        .core_set_pc_req  (core_set_pc_req),
        .core_set_pc_addr (core_set_pc_addr),
        .core_ena         (core_ena),
        .core_clr         (core_clr),
        .launch_done      (launch_done)
    );

endmodule

// ==== sim/gpu_ctrl_asserts.sv ====
`timescale 1ns/100ps

module gpu_ctrl_asserts (
    input logic clk,
    input logic rst,
    input logic mem_wr_en,
    input logic mem_rd_en,
    input logic mem_rd_ack,
    input logic core_set_pc_req,
    input logic core_ena,
    input logic core_clr
);

    // failed properties so far
    int   fail_count = 0;
    // read request waiting for its ack
    logic rd_open;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rd_open <= 1'b0;
        end else if (mem_rd_en) begin
            rd_open <= 1'b1;
        end else if (mem_rd_ack) begin
            rd_open <= 1'b0;
        end
    end

    // memory sees one direction per cycle
    wr_rd_exclusive: assert property (@(posedge clk) disable iff (!rst)
        !(mem_wr_en && mem_rd_en))
        else begin
            fail_count = fail_count + 1;
            $error("memory write and read enables high together");
        end

    // one read in flight
    single_read: assert property (@(posedge clk) disable iff (!rst)
        mem_rd_en |-> !rd_open)
        else begin
            fail_count = fail_count + 1;
            $error("second memory read before the ack");
        end

    pc_req_pulse: assert property (@(posedge clk) disable iff (!rst)
        core_set_pc_req |=> !core_set_pc_req)
        else begin
            fail_count = fail_count + 1;
            $error("core_set_pc_req longer than one cycle");
        end

    clr_pulse: assert property (@(posedge clk) disable iff (!rst)
        core_clr |=> !core_clr)
        else begin
            fail_count = fail_count + 1;
            $error("core_clr longer than one cycle");
        end

    // core is stopped while it is cleared
    clr_no_ena: assert property (@(posedge clk) disable iff (!rst)
        core_clr |-> !core_ena)
        else begin
            fail_count = fail_count + 1;
            $error("core_ena high during core_clr");
        end

endmodule

// ==== sim/gpu_ctrl_tb.sv ====
`timescale 1ns/100ps

`include "gpu_ctrl_defs.svh"

module gpu_ctrl_tb
    import gpu_ctrl_pkg::*;
();

    localparam int unsigned SEED = 32'h5e5e_daf2;
    localparam int NUM_CMDS   = 40;
    localparam int MAX_LAT    = 4;
    localparam int MAX_WORDS  = 16;
    localparam int RST_CYCLES = 16;
    // worst command is a full read at the longest memory latency
    localparam int LIMIT = RST_CYCLES + 8 + NUM_CMDS * (16 + MAX_WORDS * (MAX_LAT + 1));

    logic   clk;
    logic   rst;
    instr_e cpu_recv_instr;
    data_t  cpu_in_data;
    data_t  cpu_out_data;
    logic   cpu_out_ack;
    logic   mem_wr_en;
    addr_t  mem_wr_addr;
    data_t  mem_wr_data;
    logic   mem_rd_en;
    addr_t  mem_rd_addr;
    data_t  mem_rd_data = '0;
    logic   mem_rd_ack  = 1'b0;
    logic   core_set_pc_req;
    addr_t  core_set_pc_addr;
    logic   core_ena;
    logic   core_clr;
    logic   core_halt   = 1'b0;

    // memory as the DUT sees it, and as the host wrote it
    data_t mem_model [addr_t];
    data_t ref_mem [addr_t];
    // outputs still to come, oldest first
    addr_t exp_wr_addr [$];
    data_t exp_wr_data [$];
    addr_t exp_rd_addr [$];
    data_t exp_out [$];
    addr_t exp_pc [$];
    // written regions, candidates for read back
    addr_t region_base [$];
    int    region_words [$];
    int    clr_seen   = 0;
    int    clr_target = 0;
    int    rd_left    = 0;
    int    halt_left  = 0;
    logic  ena_q      = 1'b0;
    addr_t rd_addr_q  = '0;
    int    cycles     = 0;
    int    errors     = 0;
    int    tests      = 0;
    int    failed     = 0;

    gpu_ctrl_top i_gpu_ctrl_top (.*);

    bind gpu_ctrl_top gpu_ctrl_asserts i_gpu_ctrl_asserts (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic any_activity();
        return mem_wr_en | mem_rd_en | cpu_out_ack | core_set_pc_req | core_ena | core_clr;
    endfunction

    // words never written read back as a mix of their address
    function automatic data_t fill_word(addr_t a);
        return a ^ 32'h5a5a_0f0f;
    endfunction

    function automatic instr_e junk_opcode();
        if ($urandom_range(0, 1) == 0)
            return INSTR_NOP;
        return instr_e'($urandom_range(4, 255));
    endfunction

    // valid opcodes too, for cycles where the decoder is not idle
    function automatic instr_e busy_opcode();
        return instr_e'($urandom_range(0, 7));
    endfunction

    task automatic flag_error(input string msg);
        errors = errors + 1;
        $display("ERROR %0d ns: %s", $time, msg);
    endtask

    task automatic close_test(input string name, input int errs_at_start);
        tests = tests + 1;
        if (errors != errs_at_start) begin
            failed = failed + 1;
            $display("test %0d %s: failed", tests, name);
        end else begin
            $display("test %0d %s: ok", tests, name);
        end
    endtask

    // outputs sampled mid cycle, memory and core answers driven here too
    always @(negedge clk) begin
        cycles = cycles + 1;
        if (cycles > LIMIT) begin
            $display("timeout: commands still running after %0d cycles", LIMIT);
            $display("Simulation finished: FAIL");
            $finish;
        end else if (!rst) begin
            if (any_activity())
                flag_error("output active during reset");
        end else begin
            mem_rd_ack = 1'b0;
            if (mem_wr_en) begin
                if (exp_wr_addr.size() == 0) begin
                    flag_error("unexpected memory write");
                end else begin
                    if (mem_wr_addr !== exp_wr_addr[0] || mem_wr_data !== exp_wr_data[0])
                        flag_error($sformatf("write %h = %h, expected %h = %h", mem_wr_addr,
                                             mem_wr_data, exp_wr_addr[0], exp_wr_data[0]));
                    void'(exp_wr_addr.pop_front());
                    void'(exp_wr_data.pop_front());
                end
                mem_model[mem_wr_addr] = mem_wr_data;
            end
            // read latency countdown, answer when it runs out
            if (rd_left > 0) begin
                rd_left = rd_left - 1;
                if (rd_left == 0) begin
                    mem_rd_ack  = 1'b1;
                    mem_rd_data = mem_model.exists(rd_addr_q) ? mem_model[rd_addr_q]
                                                              : fill_word(rd_addr_q);
                end
            end
            if (mem_rd_en) begin
                if (rd_left > 0)
                    flag_error("memory read issued while another is outstanding");
                if (exp_rd_addr.size() == 0) begin
                    flag_error("unexpected memory read");
                end else begin
                    if (mem_rd_addr !== exp_rd_addr[0])
                        flag_error($sformatf("read address %h, expected %h", mem_rd_addr,
                                             exp_rd_addr[0]));
                    void'(exp_rd_addr.pop_front());
                end
                rd_addr_q = mem_rd_addr;
                rd_left   = $urandom_range(1, MAX_LAT);
            end
            if (cpu_out_ack) begin
                if (exp_out.size() == 0) begin
                    flag_error("unexpected host acknowledge");
                end else begin
                    if (cpu_out_data !== exp_out[0])
                        flag_error($sformatf("host word %h, expected %h", cpu_out_data,
                                             exp_out[0]));
                    void'(exp_out.pop_front());
                end
            end
            if (core_set_pc_req) begin
                if (exp_pc.size() == 0) begin
                    flag_error("unexpected program counter request");
                end else begin
                    if (core_set_pc_addr !== exp_pc[0])
                        flag_error($sformatf("kernel address %h, expected %h",
                                             core_set_pc_addr, exp_pc[0]));
                    void'(exp_pc.pop_front());
                end
            end
            // core model, halt some cycles after enable, held until clear
            if (core_clr) begin
                if (clr_seen >= clr_target)
                    flag_error("unexpected core clear");
                else
                    clr_seen = clr_seen + 1;
                if (!core_halt)
                    flag_error("core cleared before it halted");
                core_halt = 1'b0;
            end
            if (ena_q && !core_ena && !core_clr)
                flag_error("core enable dropped without a clear");
            if (core_ena && !ena_q) begin
                halt_left = $urandom_range(3, 20);
            end else if (halt_left > 0) begin
                halt_left = halt_left - 1;
                if (halt_left == 0)
                    core_halt = 1'b1;
            end
            ena_q = core_ena;
        end
    end

    task automatic drive(input instr_e op, input data_t word);
        @(negedge clk);
        cpu_recv_instr = op;
        cpu_in_data    = word;
    endtask

    // random opcodes on the host bus until every expected output has arrived
    task automatic drain();
        @(posedge clk);
        while (exp_wr_addr.size() + exp_rd_addr.size() + exp_out.size() + exp_pc.size() != 0 ||
               clr_seen != clr_target) begin
            @(negedge clk);
            cpu_recv_instr = busy_opcode();
            cpu_in_data    = $urandom();
            @(posedge clk);
        end
        @(negedge clk);
        cpu_recv_instr = INSTR_NOP;
    endtask

    task automatic copy_to_gpu(input addr_t base, input int words);
        data_t w;
        addr_t a;
        drive(INSTR_COPY_TO_GPU, $urandom());
        drive(busy_opcode(), base);
        drive(busy_opcode(), words * `GPU_WORD_BYTES);
        for (int k = 0; k < words; k++) begin
            w = $urandom();
            a = base + k * `GPU_WORD_BYTES;
            exp_wr_addr.push_back(a);
            exp_wr_data.push_back(w);
            ref_mem[a] = w;
            drive(busy_opcode(), w);
        end
        region_base.push_back(base);
        region_words.push_back(words);
        drain();
    endtask

    task automatic copy_from_gpu(input addr_t base, input int words);
        addr_t a;
        for (int k = 0; k < words; k++) begin
            a = base + k * `GPU_WORD_BYTES;
            exp_rd_addr.push_back(a);
            exp_out.push_back(ref_mem[a]);
        end
        drive(INSTR_COPY_FROM_GPU, $urandom());
        drive(busy_opcode(), base);
        drive(busy_opcode(), words * `GPU_WORD_BYTES);
        drain();
    endtask

    task automatic kernel_launch(input addr_t kaddr);
        exp_pc.push_back(kaddr);
        // completion word to the host is zero
        exp_out.push_back('0);
        clr_target = clr_target + 1;
        drive(INSTR_KERNEL_LAUNCH, $urandom());
        drive(busy_opcode(), kaddr);
        drain();
    endtask

    initial begin
        int    sel;
        int    pick;
        int    words;
        int    errs_at_start;
        addr_t base;
        void'($urandom(SEED));
        rst            = 1'b0;
        cpu_recv_instr = INSTR_NOP;
        cpu_in_data    = '0;
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b1;
        repeat (2) @(negedge clk);
        if (any_activity())
            flag_error("output active right after reset");
        close_test("reset", 0);
        for (int n = 0; n < NUM_CMDS; n++) begin
            sel           = $urandom_range(0, 3);
            errs_at_start = errors;
            if (sel == 0 || region_base.size() == 0) begin
                base  = 32'h0001_0000 + ($urandom_range(0, 255) << 2);
                words = $urandom_range(1, MAX_WORDS);
                copy_to_gpu(base, words);
                close_test($sformatf("copy to gpu %0d bytes at %h", words * 4, base),
                           errs_at_start);
            end else if (sel == 1) begin
                pick = $urandom_range(0, region_base.size() - 1);
                copy_from_gpu(region_base[pick], region_words[pick]);
                close_test($sformatf("copy from gpu %0d bytes at %h", region_words[pick] * 4,
                                     region_base[pick]), errs_at_start);
            end else if (sel == 2) begin
                base = $urandom() & 32'hffff_fffc;
                kernel_launch(base);
                close_test($sformatf("kernel launch at %h", base), errs_at_start);
            end else begin
                repeat ($urandom_range(2, 6))
                    drive(junk_opcode(), $urandom());
                drain();
                close_test("nop and unknown opcodes", errs_at_start);
            end
        end
        repeat (4) @(negedge clk);
        if (i_gpu_ctrl_top.i_gpu_ctrl_asserts.fail_count != 0) begin
            errors = errors + 1;
            $display("bound assertions failed %0d times",
                     i_gpu_ctrl_top.i_gpu_ctrl_asserts.fail_count);
        end
        $display("tests run %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+hw
hw/gpu_ctrl_pkg.sv
hw/cmd_decoder.sv
hw/dma_engine.sv
hw/kernel_launcher.sv
hw/gpu_ctrl_top.sv
sim/gpu_ctrl_asserts.sv
sim/gpu_ctrl_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary -sv --top-module gpu_ctrl_tb -f src.f -o gpu_ctrl_sim \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/gpu_ctrl_sim > sim.log 2>&1
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "simulation ended early"; exit 1; }
exit 0
